// ==== hdl/mg_bridge_pkg.sv ====
/*
 * shared definitions for the memory port bridge
 *   field widths, queue and buffer depths
 *   MIG instruction encoding
 *   command word, write word and buffer status structs
 *   status decode of a buffer fill count
 */
package mg_bridge_pkg;

	// command and data fields
	localparam int INSTR_W     = 3;
	localparam int BL_W        = 6;
	localparam int ADDR_W      = 30;	// byte address
	localparam int DATA_W      = 32;
	localparam int MASK_W      = 4;	// one bit per byte

	// command queue
	localparam int CMD_PTR_W   = 3;	// top bit flags full
	localparam int CMD_DEPTH   = 4;
	localparam int CMD_ADDR_W  = $clog2(CMD_DEPTH);

	// write and read buffers
	localparam int BUFF_PTR_W  = 7;
	localparam int BUFF_DEPTH  = 64;
	localparam int BUFF_ADDR_W = $clog2(BUFF_DEPTH);

	// MIG user port instruction codes
	typedef enum logic [INSTR_W-1:0] {
		INSTR_WR    = 3'b000,
		INSTR_RD    = 3'b001,
		INSTR_WR_AP = 3'b010,	// write, auto precharge
		INSTR_RD_AP = 3'b011,	// read, auto precharge
		INSTR_REF   = 3'b100
	} cmd_instr_t;

	typedef struct packed {
		cmd_instr_t              instr;
		logic [BL_W-1:0]   bl;
		logic [ADDR_W-1:0] byte_addr;
	} cmd_word_t;

	typedef struct packed {
		logic [MASK_W-1:0] mask;
		logic [DATA_W-1:0] data;
	} wr_word_t;

	typedef logic [BUFF_PTR_W-1:0] buff_count_t;

	typedef struct packed {
		buff_count_t count;
		logic        full;
		logic        empty;
		logic        error;
	} buff_status_t;

	// count is pushes minus pops, mod 128
	function automatic buff_status_t buff_status_f(input buff_count_t count);
		buff_status_t s;
		s.count = count;
		s.full  = count[BUFF_PTR_W-1];
		s.empty = (count == '0);
		s.error = count[BUFF_PTR_W-1] & (count[BUFF_PTR_W-2:0] != '0);	// overfill or underrun
		return s;
	endfunction

endpackage

// ==== hdl/mg_dp_ram.sv ====
/*
 * behavioral dual-port RAM
 *   one write port, one read port with registered output
 */
`timescale 1ns/1ps

module mg_dp_ram #(
	parameter int ADDR_BITS = 6,
	parameter int WIDTH     = 32
) (
	input  logic                 mem_clk,
	input  logic                 we,
	input  logic [ADDR_BITS-1:0] waddr,
	input  logic [WIDTH-1:0]     wdata,
	input  logic [ADDR_BITS-1:0] raddr,
	output logic [WIDTH-1:0]     rdata
);

	logic [WIDTH-1:0] mem [0:(1<<ADDR_BITS)-1];

	always_ff @(posedge mem_clk)
	begin
		if (we)
			mem[waddr] <= wdata;
	end

	// a write to the read address shows one edge later
	always_ff @(posedge mem_clk)
	begin
		rdata <= mem[raddr];
	end

endmodule

// ==== hdl/mg_cmd_queue.sv ====
/*
 * four-entry command queue
 *   user side push with full and empty flags
 *   memory side held request with acknowledge
 */
`timescale 1ns/1ps

module mg_cmd_queue
	import mg_bridge_pkg::*;
(
	input  logic      mem_clk,
	input  logic      mem_rst_n,
	// user side
	input  logic      cmd_en,
	input  cmd_word_t cmd,
	output logic      cmd_full,
	output logic      cmd_empty,
	// memory side
	output logic      mem_cmd_req,
	output cmd_word_t mem_cmd,
	input  logic      mem_cmd_ack
);

	logic [CMD_PTR_W-1:0]        wr_ptr;
	logic [CMD_PTR_W-1:0]        rd_ptr;
	logic [CMD_PTR_W-1:0]        rd_ptr_next;
	logic [CMD_PTR_W-1:0]        fill;
	logic                        pop;
	logic [$bits(cmd_word_t)-1:0] head_raw;

	// ------------------------------------------------------------
	// pointers and flags
	// ------------------------------------------------------------

	assign pop         = mem_cmd_req & mem_cmd_ack;	// stray ack ignored
	assign rd_ptr_next = rd_ptr + CMD_PTR_W'(pop);

	assign fill      = wr_ptr - rd_ptr;
	assign cmd_full  = fill[CMD_PTR_W-1];	// all four entries taken
	assign cmd_empty = (fill == '0);

	always_ff @(posedge mem_clk or negedge mem_rst_n)
	begin
		if (!mem_rst_n)
		begin
			wr_ptr <= '0;
		end
		else if (cmd_en)
		begin
			wr_ptr <= wr_ptr + 1'b1;
		end
	end

	always_ff @(posedge mem_clk or negedge mem_rst_n)
	begin
		if (!mem_rst_n)
		begin
			rd_ptr <= '0;
		end
		else
		begin
			rd_ptr <= rd_ptr_next;
		end
	end

	// ------------------------------------------------------------
	// memory request
	// ------------------------------------------------------------

	// drops for one cycle after each ack, the next head
	// settles in the RAM output meanwhile
	always_ff @(posedge mem_clk or negedge mem_rst_n)
	begin
		if (!mem_rst_n)
		begin
			mem_cmd_req <= 1'b0;
		end
		else
		begin
			mem_cmd_req <= !cmd_empty & !pop;
		end
	end

	// command store, read side tracks the next head
	mg_dp_ram #(
		.ADDR_BITS (CMD_ADDR_W),
		.WIDTH     ($bits(cmd_word_t))
	) cmd_ram_i (
		.mem_clk (mem_clk),
		.we      (cmd_en),
		.waddr   (wr_ptr[CMD_ADDR_W-1:0]),
		.wdata   (cmd),
		.raddr   (rd_ptr_next[CMD_ADDR_W-1:0]),
		.rdata   (head_raw)
	);

	assign mem_cmd = cmd_word_t'(head_raw);

endmodule

// ==== hdl/mg_wr_buff.sv ====
/*
 * 64-word write buffer
 *   user push of data with byte mask
 *   show-ahead head toward memory, popped by ack
 *   fill count, full, empty and error status
 */
`timescale 1ns/1ps

module mg_wr_buff
	import mg_bridge_pkg::*;
(
	input  logic         mem_clk,
	input  logic         mem_rst_n,
	input  logic         wr_en,
	input  wr_word_t     wr_word,
	output wr_word_t     mem_wr,
	input  logic         mem_wr_ack,
	output buff_status_t status
);

	buff_count_t push_ptr;
	buff_count_t pop_ptr;
	buff_count_t pop_ptr_next;
	logic [$bits(wr_word_t)-1:0] head_raw;

	// ------------------------------------------------------------
	// pointers
	// ------------------------------------------------------------

	assign pop_ptr_next = pop_ptr + BUFF_PTR_W'(mem_wr_ack);

	always_ff @(posedge mem_clk or negedge mem_rst_n)
	begin
		if (!mem_rst_n)
		begin
			push_ptr <= '0;
			pop_ptr  <= '0;
		end
		else
		begin
			if (wr_en)
				push_ptr <= push_ptr + 1'b1;
			pop_ptr <= pop_ptr_next;	// not gated, underrun shows as error
		end
	end

	assign status = buff_status_f(push_ptr - pop_ptr);

	// ------------------------------------------------------------
	// word store
	// ------------------------------------------------------------

	mg_dp_ram #(
		.ADDR_BITS (BUFF_ADDR_W),
		.WIDTH     ($bits(wr_word_t))
	) wr_ram_i (
		.mem_clk (mem_clk),
		.we      (wr_en),
		.waddr   (push_ptr[BUFF_ADDR_W-1:0]),
		.wdata   (wr_word),
		.raddr   (pop_ptr_next[BUFF_ADDR_W-1:0]),	// next head, one edge ahead
		.rdata   (head_raw)
	);

	assign mem_wr = wr_word_t'(head_raw);

endmodule

// ==== hdl/mg_rd_buff.sv ====
/*
 * 64-word read buffer
 *   memory push of read data
 *   show-ahead head toward the user port, popped by rd_en
 *   fill count, full, empty and error status
 */
`timescale 1ns/1ps

module mg_rd_buff
	import mg_bridge_pkg::*;
(
	input  logic              mem_clk,
	input  logic              mem_rst_n,
	input  logic              mem_rd_req,
	input  logic [DATA_W-1:0] mem_rd_data,
	input  logic              rd_en,
	output logic [DATA_W-1:0] rd_data,
	output buff_status_t      status
);

	buff_count_t push_ptr;
	buff_count_t pop_ptr;
	buff_count_t pop_ptr_next;

	// ------------------------------------------------------------
	// pointers
	// ------------------------------------------------------------

	assign pop_ptr_next = pop_ptr + BUFF_PTR_W'(rd_en);

	always_ff @(posedge mem_clk or negedge mem_rst_n)
	begin
		if (!mem_rst_n)
		begin
			push_ptr <= '0;
			pop_ptr  <= '0;
		end
		else
		begin
			if (mem_rd_req)
				push_ptr <= push_ptr + 1'b1;	// one word per request cycle
			pop_ptr <= pop_ptr_next;
		end
	end

	// wraps past 64 on overflow, error flags it
	assign status = buff_status_f(push_ptr - pop_ptr);

	// ------------------------------------------------------------
	// word store
	// ------------------------------------------------------------

	mg_dp_ram #(
		.ADDR_BITS (BUFF_ADDR_W),
		.WIDTH     (DATA_W)
	) rd_ram_i (
		.mem_clk (mem_clk),
		.we      (mem_rd_req),
		.waddr   (push_ptr[BUFF_ADDR_W-1:0]),
		.wdata   (mem_rd_data),
		.raddr   (pop_ptr_next[BUFF_ADDR_W-1:0]),
		.rdata   (rd_data)
	);

endmodule

// ==== hdl/mg_port_bridge.sv ====
/*
 * memory port bridge top level
 *   command queue, write buffer and read buffer
 *   MIG-style user port on one side, memory requests on the other
 */
`timescale 1ns/1ps

module mg_port_bridge
	import mg_bridge_pkg::*;
(
	input  logic              mem_clk,
	input  logic              mem_rst_n,

	// user command port
	input  logic              cmd_en,
	input  cmd_word_t         cmd,
	output logic              cmd_full,
	output logic              cmd_empty,

	// user write and read ports
	input  logic              wr_en,
	input  wr_word_t          wr_word,
	input  logic              rd_en,
	output logic [DATA_W-1:0] rd_data,
	output buff_status_t      wr_status,
	output buff_status_t      rd_status,

	// memory side
	output logic              mem_cmd_req,
	output cmd_word_t         mem_cmd,
	input  logic              mem_cmd_ack,
	output wr_word_t          mem_wr,
	input  logic              mem_wr_ack,
	input  logic              mem_rd_req,
	input  logic [DATA_W-1:0] mem_rd_data
);

	// ------------------------------------------------------------
	// command path
	// ------------------------------------------------------------

	mg_cmd_queue cmd_queue_i (
		.mem_clk     (mem_clk),
		.mem_rst_n   (mem_rst_n),
		.cmd_en      (cmd_en),
		.cmd         (cmd),
		.cmd_full    (cmd_full),
		.cmd_empty   (cmd_empty),
		.mem_cmd_req (mem_cmd_req),
		.mem_cmd     (mem_cmd),
		.mem_cmd_ack (mem_cmd_ack)
	);

	// ------------------------------------------------------------
	// data paths
	// ------------------------------------------------------------

	mg_wr_buff wr_buff_i (
		.mem_clk    (mem_clk),
		.mem_rst_n  (mem_rst_n),
		.wr_en      (wr_en),
		.wr_word    (wr_word),
		.mem_wr     (mem_wr),
		.mem_wr_ack (mem_wr_ack),
		.status     (wr_status)
	);

	mg_rd_buff rd_buff_i (
		.mem_clk     (mem_clk),
		.mem_rst_n   (mem_rst_n),
		.mem_rd_req  (mem_rd_req),
		.mem_rd_data (mem_rd_data),
		.rd_en       (rd_en),
		.rd_data     (rd_data),
		.status      (rd_status)
	);

endmodule

// ==== tests/tb_mg_port_bridge.sv ====
/*
 * testbench for the memory port bridge
 *   clock, reset and test record reader
 *   Galois LFSR for ack gaps, compare tasks, watchdog
 */
`timescale 1ns/1ps

module tb_mg_port_bridge
	import mg_bridge_pkg::*;
;

	localparam int    CLK_PERIOD = 40;
	localparam int    DRIVE_DLY  = 5;	// after the rising edge
	localparam string TEST_FILE  = "tests/mg_bridge_tests.dat";

	typedef struct packed {
		logic [3:0]  op;
		logic [7:0]  n;	// word count, or status select
		logic [63:0] arg;
		logic [63:0] exp;
	} test_rec_t;

	logic              mem_clk;
	logic              mem_rst_n;
	logic              cmd_en, cmd_full, cmd_empty;
	cmd_word_t         cmd, mem_cmd;
	logic              wr_en, rd_en;
	wr_word_t          wr_word, mem_wr;
	logic [DATA_W-1:0] rd_data, mem_rd_data;
	buff_status_t      wr_status, rd_status;
	logic              mem_cmd_req, mem_cmd_ack, mem_wr_ack, mem_rd_req;

	test_rec_t   recs[$];
	logic [15:0] lfsr_state;
	int          budget_cycles = 0;

	mg_port_bridge dut_i (.*);

	initial
	begin
		mem_clk = 1'b0;
		forever #(CLK_PERIOD/2) mem_clk = ~mem_clk;
	end

	// ------------------------------------------------------------
	// helpers and compare tasks
	// ------------------------------------------------------------

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Testbench failed");
		$fatal(1, "run stopped");
	endtask

	task automatic report_error(input string msg);
		$display("Error at %0t ns: %s", $time, msg);
		abort_run("stopping at the first mismatch");
	endtask

	task automatic check_cmd(input cmd_word_t actual, input cmd_word_t expected);
		if (actual !== expected)
			report_error($sformatf("mem_cmd is %h, expected %h", actual, expected));
	endtask

	task automatic check_wr(input wr_word_t actual, input wr_word_t expected);
		if (actual !== expected)
			report_error($sformatf("mem_wr is %h, expected %h", actual, expected));
	endtask

	task automatic check_data(input logic [DATA_W-1:0] actual,
		input logic [DATA_W-1:0] expected);
		if (actual !== expected)
			report_error($sformatf("rd_data is %h, expected %h", actual, expected));
	endtask

	task automatic check_status(input string what, input buff_status_t actual,
		input buff_status_t expected);
		if (actual !== expected)
			report_error($sformatf("%s is %h, expected %h", what, actual, expected));
	endtask

	task automatic check_count(input string what, input buff_count_t actual,
		input buff_count_t expected);
		if (actual !== expected)
			report_error($sformatf("%s is %0d, expected %0d", what, actual, expected));
	endtask

	task automatic check_flag(input string what, input logic actual, input logic expected);
		if (actual !== expected)
			report_error($sformatf("%s is %b, expected %b", what, actual, expected));
	endtask

	task automatic next_cycle();
		@(posedge mem_clk);
		#DRIVE_DLY;
	endtask

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	task automatic random_gap(output int gap);
		gap = 0;
		repeat (2)
		begin
			gap = (gap << 1) | lfsr_state[0];	// one step per bit
			lfsr_state = lfsr_next(lfsr_state);
		end
	endtask

	task automatic wait_gap();
		int gap;
		random_gap(gap);
		repeat (gap) next_cycle();
	endtask

	// ------------------------------------------------------------
	// record execution
	// ------------------------------------------------------------

	task automatic run_record(input test_rec_t r);
		case (r.op)
			4'h1:
			begin
				cmd_en = 1'b1;
				cmd    = cmd_word_t'(r.arg[$bits(cmd_word_t)-1:0]);
				next_cycle();
				cmd_en = 1'b0;
				check_flag("cmd_full", cmd_full, r.exp[0]);
			end
			4'h2:
			begin
				while (!mem_cmd_req)
					next_cycle();
				wait_gap();	// request is held meanwhile
				check_cmd(mem_cmd, cmd_word_t'(r.exp[$bits(cmd_word_t)-1:0]));
				mem_cmd_ack = 1'b1;
				next_cycle();
				mem_cmd_ack = 1'b0;
			end
			4'h3:
			begin
				wr_en   = 1'b1;
				wr_word = wr_word_t'(r.arg[$bits(wr_word_t)-1:0]);
				next_cycle();
				wr_en = 1'b0;
				check_count("write count", wr_status.count, buff_count_t'(r.exp));
			end
			4'h4:
			begin
				while (wr_status.empty)
					next_cycle();
				next_cycle();	// show-ahead head settles
				wait_gap();
				check_wr(mem_wr, wr_word_t'(r.exp[$bits(wr_word_t)-1:0]));
				mem_wr_ack = 1'b1;
				next_cycle();
				mem_wr_ack = 1'b0;
			end
			4'h5:
			begin
				for (int i = 0; i < r.n; i++)
				begin
					mem_rd_req  = 1'b1;
					mem_rd_data = DATA_W'(r.arg + i);
					next_cycle();
				end
				mem_rd_req = 1'b0;
				check_count("read count", rd_status.count, buff_count_t'(r.exp));
			end
			4'h6:
			begin
				for (int i = 0; i < r.n; i++)
				begin
					while (rd_status.empty)
						next_cycle();
					next_cycle();
					check_data(rd_data, DATA_W'(r.exp + i));
					rd_en = 1'b1;
					next_cycle();
					rd_en = 1'b0;
				end
			end
			4'h7:
			begin
				if (r.n == 0)
					check_status("write status", wr_status, buff_status_t'(r.exp[9:0]));
				else if (r.n == 1)
					check_status("read status", rd_status, buff_status_t'(r.exp[9:0]));
				else
				begin
					next_cycle();	// request level settles one edge past an ack
					check_flag("mem_cmd_req", mem_cmd_req, r.exp[2]);
					check_flag("cmd_full", cmd_full, r.exp[1]);
					check_flag("cmd_empty", cmd_empty, r.exp[0]);
				end
			end
			default:
				abort_run($sformatf("unknown operation code %0h in the test data", r.op));
		endcase
	endtask

	task automatic load_records();
		int          fd;
		int          got;
		string       line;
		logic [63:0] f_op, f_n, f_arg, f_exp;
		fd = $fopen(TEST_FILE, "r");
		if (fd == 0)
			abort_run("could not open the test data file");
		while (!$feof(fd))
		begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() < 2 || line[0] == "#")
				continue;	// blank or column notes
			got = $sscanf(line, "%h %h %h %h", f_op, f_n, f_arg, f_exp);
			if (got != 4)
				abort_run("a line of the test data file is not a valid record");
			recs.push_back('{f_op[3:0], f_n[7:0], f_arg, f_exp});
		end
		$fclose(fd);
	endtask

	// ------------------------------------------------------------
	// main sequence and watchdog
	// ------------------------------------------------------------

	initial
	begin
		int words;
		mem_rst_n   = 1'b0;
		cmd_en      = 1'b0;
		cmd         = '0;
		wr_en       = 1'b0;
		wr_word     = '0;
		rd_en       = 1'b0;
		mem_cmd_ack = 1'b0;
		mem_wr_ack  = 1'b0;
		mem_rd_req  = 1'b0;
		mem_rd_data = '0;
		lfsr_state  = 16'd41;
		load_records();
		words = 4;
		foreach (recs[i])
			words += (recs[i].op == 4'h5 || recs[i].op == 4'h6) ? recs[i].n : 1;
		budget_cycles = words * 20;
		repeat (2) @(posedge mem_clk);
		#DRIVE_DLY mem_rst_n = 1'b1;
		foreach (recs[i])
			run_record(recs[i]);
		next_cycle();
		$display("Testbench passed");
		$finish;
	end

	initial
	begin
		wait (budget_cycles > 0);
		repeat (budget_cycles) @(posedge mem_clk);
		abort_run($sformatf("timeout, tests still running after %0d cycles", budget_cycles));
	end

endmodule

// ==== tests/mg_bridge_tests.dat ====
# columns, all hex: op  n_or_select  operand  expected
# op 1 push cmd, 2 ack cmd, 3 push wr, 4 ack wr, 5 mem read words, 6 user read, 7 status
7 0 0 002
7 1 0 002
7 2 0 1
1 1 03C0001000 0
1 1 11C0002040 0
1 1 2FFFFFFFFC 0
1 1 4000000000 1
7 2 0 6
2 1 0 03C0001000
2 1 0 11C0002040
2 1 0 2FFFFFFFFC
2 1 0 4000000000
7 2 0 1
1 1 3040000800 0
2 1 0 3040000800
7 2 0 1
# write path with byte masks
3 1 F11223344 1
3 1 3A5A50001 2
3 1 8C0FFEE00 3
7 0 0 018
4 1 0 F11223344
7 0 0 010
4 1 0 3A5A50001
4 1 0 8C0FFEE00
7 0 0 002
3 1 5FEDCBA98 1
4 1 0 5FEDCBA98
7 0 0 002
# read path
5 3 00000100 3
7 1 0 018
6 2 0 00000100
7 1 0 008
6 1 0 00000102
7 1 0 002
5 40 00005000 40
7 1 0 204
6 40 0 00005000
7 1 0 002
5 40 00006000 40
7 1 0 204
5 1 00006040 41
7 1 0 20D

// ==== filelist.f ====
hdl/mg_bridge_pkg.sv
hdl/mg_dp_ram.sv
hdl/mg_cmd_queue.sv
hdl/mg_wr_buff.sv
hdl/mg_rd_buff.sv
hdl/mg_port_bridge.sv
tests/tb_mg_port_bridge.sv
